//--- design/ppu_reg_pkg.sv
package ppu_reg_pkg;

    localparam int DATA_W = 8;

    // PPUDATA address regions with palette space above NT_LAST
    localparam logic [13:0] CHR_LAST = 14'h1FFF;
    localparam logic [13:0] NT_LAST  = 14'h3EFF;

    // vaddr steps after each PPUDATA access
    localparam logic [14:0] INC_ACROSS = 15'd1;
    localparam logic [14:0] INC_DOWN   = 15'd32;

    // cpu-visible register selects where 3 and 4 stay unused
    typedef enum logic [2:0] {
        PPUCTRL   = 3'd0,
        PPUMASK   = 3'd1,
        PPUSTATUS = 3'd2,
        PPUSCROLL = 3'd5,
        PPUADDR   = 3'd6,
        PPUDATA   = 3'd7
    } reg_sel_e;

    typedef enum logic {
        MIRROR_VERT = 1'b0,
        MIRROR_HORZ = 1'b1
    } mirror_e;

    // scroll fields for PPUSCROLL, byte halves for PPUADDR
    typedef union packed {
        struct packed {
            logic [2:0] fine_y;
            logic [1:0] nt;
            logic [4:0] coarse_y;
            logic [4:0] coarse_x;
        } fields;
        struct packed {
            logic [6:0] hi;
            logic [7:0] lo;
        } split;
    } vram_addr_u;

    // rw high means write
    typedef struct packed {
        reg_sel_e          sel;
        logic              en;
        logic              rw;
        logic [DATA_W-1:0] data;
    } cpu_bus_t;

    typedef struct packed {
        logic [10:0]       addr;
        logic              we;
        logic              re;
        logic [DATA_W-1:0] wr_data;
    } mem_req_t;

    typedef struct packed {
        logic sp_over_set;
        logic sp_over_clr;
        logic sp_zero_set;
        logic sp_zero_clr;
        logic vblank_set;
        logic vblank_clr;
    } status_evt_t;

endpackage

//--- design/reg_access.sv
`timescale 1ns/1ps

module reg_access (
    input  logic                  clk,
    input  logic                  rst_n,
    input  ppu_reg_pkg::cpu_bus_t bus,
    input  logic [7:0]            status,
    input  logic [7:0]            ppudata_rd,
    input  logic                  ppudata_rd_valid,
    output logic [7:0]            reg_data_out,
    output logic [7:0]            ppuctrl,
    output logic [7:0]            ppumask,
    output logic                  wr_ctrl_nt,
    output logic                  wr_scroll,
    output logic                  wr_addr,
    output logic                  rd_status,
    output logic                  data_acc,
    output logic                  data_write,
    output logic                  wr_any
);

    logic wr_ctrl;
    logic wr_mask;
    logic rd_data;

    // bus decode
    always_comb begin
        wr_ctrl    = 1'b0;
        wr_mask    = 1'b0;
        wr_scroll  = 1'b0;
        wr_addr    = 1'b0;
        rd_status  = 1'b0;
        data_acc   = 1'b0;
        data_write = 1'b0;
        if (bus.en) begin
            case (bus.sel)
                ppu_reg_pkg::PPUCTRL:   wr_ctrl   = bus.rw;
                ppu_reg_pkg::PPUMASK:   wr_mask   = bus.rw;
                ppu_reg_pkg::PPUSTATUS: rd_status = ~bus.rw;
                ppu_reg_pkg::PPUSCROLL: wr_scroll = bus.rw;
                ppu_reg_pkg::PPUADDR:   wr_addr   = bus.rw;
                ppu_reg_pkg::PPUDATA: begin
                    data_acc   = 1'b1;
                    data_write = bus.rw;
                end
                default: ;
            endcase
        end
    end

    // nametable select bits of ppuctrl also go to the temporary address
    assign wr_ctrl_nt = wr_ctrl;
    // every write, even to an unused select, lands in the status low bits
    assign wr_any     = bus.en & bus.rw;
    assign rd_data    = data_acc & ~data_write;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ppuctrl <= 8'd0;
            ppumask <= 8'd0;
        end else begin
            if (wr_ctrl) begin
                ppuctrl <= bus.data;
            end
            if (wr_mask) begin
                ppumask <= bus.data;
            end
        end
    end

    // read data holds between reads
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_data_out <= 8'd0;
        end else if (rd_status) begin
            reg_data_out <= status;
        end else if (rd_data && ppudata_rd_valid) begin
            reg_data_out <= ppudata_rd;
        end
    end

endmodule

//--- design/loopy_addr_regs.sv
`timescale 1ns/1ps

module loopy_addr_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    wr_ctrl_nt,
    input  logic                    wr_scroll,
    input  logic                    wr_addr,
    input  logic                    rd_status,
    input  logic                    data_acc,
    input  logic                    inc_down,
    input  logic [7:0]              wr_data,
    output ppu_reg_pkg::vram_addr_u vaddr,
    output logic [2:0]              fine_x
);

    ppu_reg_pkg::vram_addr_u t_addr;
    logic [14:0]             inc_amt;
    // shared by PPUSCROLL and PPUADDR
    logic                    second_wr;

    assign inc_amt = inc_down ? ppu_reg_pkg::INC_DOWN : ppu_reg_pkg::INC_ACROSS;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            t_addr    <= '0;
            vaddr     <= '0;
            fine_x    <= 3'd0;
            second_wr <= 1'b0;
        end else begin
            if (wr_ctrl_nt) begin
                t_addr.fields.nt <= wr_data[1:0];
            end

            if (wr_scroll) begin
                second_wr <= ~second_wr;
                if (!second_wr) begin
                    fine_x                 <= wr_data[2:0];
                    t_addr.fields.coarse_x <= wr_data[7:3];
                end else begin
                    t_addr.fields.fine_y   <= wr_data[2:0];
                    t_addr.fields.coarse_y <= wr_data[7:3];
                end
            end

            if (wr_addr) begin
                second_wr <= ~second_wr;
                if (!second_wr) begin
                    t_addr.split.hi <= wr_data[6:0];
                end else begin
                    t_addr.split.lo <= wr_data;
                    // copy uses the new low byte, not the old t_addr
                    vaddr           <= {t_addr.split.hi, wr_data};
                end
            end

            if (data_acc) begin
                vaddr <= vaddr + inc_amt;
            end

            if (rd_status) begin
                second_wr <= 1'b0;
            end
        end
    end

endmodule

//--- design/ppudata_port.sv
`timescale 1ns/1ps

module ppudata_port (
    input  logic                    clk,
    input  logic                    rst_n,
    input  ppu_reg_pkg::vram_addr_u vaddr,
    input  ppu_reg_pkg::mirror_e    mirroring,
    input  logic                    data_acc,
    input  logic                    data_write,
    input  logic [7:0]              wr_data,
    input  logic [7:0]              vram_rd_data,
    input  logic [7:0]              pal_rd_data,
    output ppu_reg_pkg::mem_req_t   vram_req,
    output ppu_reg_pkg::mem_req_t   pal_req,
    output logic [7:0]              ppudata_rd,
    output logic                    ppudata_rd_valid
);

    logic [13:0] addr;
    logic        in_chr;
    logic        in_nt;
    logic        in_pal;
    logic [10:0] nt_addr;
    logic [4:0]  pal_idx;
    logic [7:0]  rd_buf;

    // top bit of the 15-bit vaddr is outside the ppu bus
    assign addr   = {vaddr.split.hi[5:0], vaddr.split.lo};
    assign in_chr = (addr <= ppu_reg_pkg::CHR_LAST);
    assign in_pal = (addr > ppu_reg_pkg::NT_LAST);
    assign in_nt  = ~in_chr & ~in_pal;

    // horizontal mirroring picks the nametable from bit 11
    assign nt_addr = (mirroring == ppu_reg_pkg::MIRROR_HORZ) ? {addr[11], addr[9:0]}
                                                             : addr[10:0];

    // sprite backdrop entries share the background ones
    assign pal_idx = (addr[4] && addr[1:0] == 2'b00) ? {1'b0, addr[3:0]} : addr[4:0];

    always_comb begin
        vram_req.addr    = nt_addr;
        vram_req.we      = data_acc & data_write & in_nt;
        vram_req.re      = data_acc & ~data_write & in_nt;
        vram_req.wr_data = wr_data;

        pal_req.addr     = {6'd0, pal_idx};
        pal_req.we       = data_acc & data_write & in_pal;
        pal_req.re       = data_acc & ~data_write & in_pal;
        pal_req.wr_data  = wr_data;
    end

    // nametable reads lag by one access
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_buf <= 8'd0;
        end else if (vram_req.re) begin
            rd_buf <= vram_rd_data;
        end
    end

    assign ppudata_rd       = in_pal ? pal_rd_data : rd_buf;
    assign ppudata_rd_valid = ~in_chr;

endmodule

//--- design/ppu_status_flags.sv
`timescale 1ns/1ps

module ppu_status_flags (
    input  logic                     clk,
    input  logic                     rst_n,
    input  ppu_reg_pkg::status_evt_t evt,
    input  logic                     rd_status,
    input  logic                     wr_any,
    input  logic [7:0]               wr_data,
    output logic [7:0]               status
);

    logic       vblank;
    logic       sp_zero;
    logic       sp_over;
    logic [4:0] last_wr;

    // later assignment wins, so each clear sits after its set
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vblank  <= 1'b0;
            sp_zero <= 1'b0;
            sp_over <= 1'b0;
            last_wr <= 5'd0;
        end else begin
            if (evt.sp_over_set) sp_over <= 1'b1;
            if (evt.sp_over_clr) sp_over <= 1'b0;
            if (evt.sp_zero_set) sp_zero <= 1'b1;
            if (evt.sp_zero_clr) sp_zero <= 1'b0;
            if (evt.vblank_set)  vblank  <= 1'b1;
            // reading the register also ends vblank
            if (evt.vblank_clr || rd_status) vblank <= 1'b0;
            if (wr_any) last_wr <= wr_data[4:0];
        end
    end

    assign status = {vblank, sp_zero, sp_over, last_wr};

endmodule

//--- design/ppu_reg_top.sv
`timescale 1ns/1ps

module ppu_reg_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  ppu_reg_pkg::cpu_bus_t   bus,
    input  ppu_reg_pkg::mirror_e    mirroring,
    input  ppu_reg_pkg::status_evt_t evt,
    input  logic [7:0]              vram_rd_data,
    input  logic [7:0]              pal_rd_data,
    output logic [7:0]              reg_data_out,
    output logic [7:0]              ppuctrl,
    output logic [7:0]              ppumask,
    output ppu_reg_pkg::vram_addr_u vaddr,
    output logic [2:0]              fine_x,
    output ppu_reg_pkg::mem_req_t   vram_req,
    output ppu_reg_pkg::mem_req_t   pal_req
);

    // one-cycle strobes decoded from the bus
    logic wr_ctrl_nt;
    logic wr_scroll;
    logic wr_addr;
    logic rd_status;
    logic data_acc;
    logic data_write;
    logic wr_any;

    logic [7:0] status;
    logic [7:0] ppudata_rd;
    logic       ppudata_rd_valid;

    reg_access u_reg_access (
        .clk              (clk),
        .rst_n            (rst_n),
        .bus              (bus),
        .status           (status),
        .ppudata_rd       (ppudata_rd),
        .ppudata_rd_valid (ppudata_rd_valid),
        .reg_data_out     (reg_data_out),
        .ppuctrl          (ppuctrl),
        .ppumask          (ppumask),
        .wr_ctrl_nt       (wr_ctrl_nt),
        .wr_scroll        (wr_scroll),
        .wr_addr          (wr_addr),
        .rd_status        (rd_status),
        .data_acc         (data_acc),
        .data_write       (data_write),
        .wr_any           (wr_any)
    );

    // ppuctrl bit 2 selects the step of 32
    loopy_addr_regs u_loopy_addr_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_ctrl_nt (wr_ctrl_nt),
        .wr_scroll  (wr_scroll),
        .wr_addr    (wr_addr),
        .rd_status  (rd_status),
        .data_acc   (data_acc),
        .inc_down   (ppuctrl[2]),
        .wr_data    (bus.data),
        .vaddr      (vaddr),
        .fine_x     (fine_x)
    );

    ppudata_port u_ppudata_port (
        .clk              (clk),
        .rst_n            (rst_n),
        .vaddr            (vaddr),
        .mirroring        (mirroring),
        .data_acc         (data_acc),
        .data_write       (data_write),
        .wr_data          (bus.data),
        .vram_rd_data     (vram_rd_data),
        .pal_rd_data      (pal_rd_data),
        .vram_req         (vram_req),
        .pal_req          (pal_req),
        .ppudata_rd       (ppudata_rd),
        .ppudata_rd_valid (ppudata_rd_valid)
    );

    ppu_status_flags u_ppu_status_flags (
        .clk       (clk),
        .rst_n     (rst_n),
        .evt       (evt),
        .rd_status (rd_status),
        .wr_any    (wr_any),
        .wr_data   (bus.data),
        .status    (status)
    );

endmodule

//--- sim/tb_ppu_reg.sv
`timescale 1ns/1ps

module tb_ppu_reg;

    localparam real CLK_PERIOD      = 4.0;
    localparam int  NUM_TESTS       = 6;
    localparam int  CYCLES_PER_TEST = 200;

    logic                     clk;
    logic                     rst_n;
    ppu_reg_pkg::cpu_bus_t    bus;
    ppu_reg_pkg::mirror_e     mirroring;
    ppu_reg_pkg::status_evt_t evt;
    logic [7:0]               vram_rd_data;
    logic [7:0]               pal_rd_data;
    logic [7:0]               reg_data_out;
    logic [7:0]               ppuctrl;
    logic [7:0]               ppumask;
    ppu_reg_pkg::vram_addr_u  vaddr;
    logic [2:0]               fine_x;
    ppu_reg_pkg::mem_req_t    vram_req;
    ppu_reg_pkg::mem_req_t    pal_req;

    logic [7:0]  nt_mem [0:2047];
    logic [7:0]  pal_mem [0:31];
    logic [31:0] lfsr;
    // reference read buffer and low bits of the last written byte
    logic [7:0]  exp_buf;
    logic [4:0]  exp_low;
    int          err_count;

    logic [7:0]  c, m, d, sx, sy, a_hi, a_lo, prev;
    logic [13:0] na, pa;
    logic [14:0] t;
    ppu_reg_pkg::mirror_e     mode;
    ppu_reg_pkg::status_evt_t e;

    ppu_reg_top i_dut (.*);

    always #(CLK_PERIOD / 2.0) clk = ~clk;

    // reads are asynchronous and writes land at the edge of the access
    assign vram_rd_data = nt_mem[vram_req.addr];
    assign pal_rd_data  = pal_mem[pal_req.addr[4:0]];

    always @(posedge clk) begin
        if (vram_req.we) begin
            nt_mem[vram_req.addr] = vram_req.wr_data;
        end
        if (pal_req.we) begin
            pal_mem[pal_req.addr[4:0]] = pal_req.wr_data;
        end
    end

    task automatic report_failure(input string what);
        err_count++;
        $display("%s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [15:0] expected,
                         input logic [15:0] actual);
        assert (actual === expected)
        else report_failure($sformatf("mismatch %s: expected %h, actual %h",
                                      name, expected, actual));
    endtask

    wr_only_on_data: assert property (@(posedge clk) disable iff (!rst_n)
        (vram_req.we || pal_req.we) |-> (bus.en && bus.rw && bus.sel == ppu_reg_pkg::PPUDATA))
    else report_failure("memory write request raised without a PPUDATA write");

    one_port_only: assert property (@(posedge clk) disable iff (!rst_n)
        !((vram_req.we || vram_req.re) && (pal_req.we || pal_req.re)))
    else report_failure("nametable and palette requests raised in the same cycle");

    // galois lfsr, one step per bit
    function automatic logic [7:0] rand_byte();
        logic [7:0] b;
        for (int i = 0; i < 8; i++) begin
            b[i] = lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return b;
    endfunction

    // vertical keeps tables 0/1 apart, horizontal keeps 0/2 apart
    function automatic logic [10:0] mirror_index(input logic [13:0] a,
                                                 input ppu_reg_pkg::mirror_e mm);
        logic page;
        page = (mm == ppu_reg_pkg::MIRROR_VERT) ? a[10] : a[11];
        return {page, a[9:0]};
    endfunction

    function automatic logic [4:0] pal_index(input logic [13:0] a);
        logic [4:0] i;
        i = a[4:0];
        if (i == 5'h10 || i == 5'h14 || i == 5'h18 || i == 5'h1C) begin
            i = i - 5'h10;
        end
        return i;
    endfunction

    // starts at 0.5 ns after an edge, returns at the same point one cycle later
    task automatic start_access(input ppu_reg_pkg::reg_sel_e sel, input logic rw,
                                input logic [7:0] data);
        bus.sel  = sel;
        bus.en   = 1'b1;
        bus.rw   = rw;
        bus.data = data;
        if (rw) begin
            exp_low = data[4:0];
        end
    endtask

    task automatic finish_access();
        @(posedge clk);
        #0.5;
        bus.en = 1'b0;
        bus.rw = 1'b0;
    endtask

    task automatic bus_cycle(input ppu_reg_pkg::reg_sel_e sel, input logic rw,
                             input logic [7:0] data);
        start_access(sel, rw, data);
        finish_access();
    endtask

    task automatic read_status();
        bus_cycle(ppu_reg_pkg::PPUSTATUS, 1'b0, 8'h00);
    endtask

    task automatic check_status(input string name, input logic [2:0] flags);
        read_status();
        check(name, 16'({flags, exp_low}), 16'(reg_data_out));
    endtask

    task automatic set_vaddr(input logic [13:0] a);
        read_status();
        bus_cycle(ppu_reg_pkg::PPUADDR, 1'b1, {2'b00, a[13:8]});
        bus_cycle(ppu_reg_pkg::PPUADDR, 1'b1, a[7:0]);
    endtask

    task automatic pulse_evt(input ppu_reg_pkg::status_evt_t pe);
        evt = pe;
        @(posedge clk);
        #0.5;
        evt = '0;
    endtask

    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        report_failure("timeout: the tests did not finish in the expected time");
    end

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        bus       = '0;
        mirroring = ppu_reg_pkg::MIRROR_VERT;
        evt       = '0;
        lfsr      = 32'h03a5eba5;
        exp_buf   = 8'h00;
        exp_low   = 5'd0;
        err_count = 0;
        for (int i = 0; i < 2048; i++) begin
            nt_mem[i] = 8'(i ^ (i >> 8) ^ 'h5a);
        end
        for (int i = 0; i < 32; i++) begin
            pal_mem[i] = 8'(i * 7 + 'h40);
        end
        repeat (3) @(posedge clk);
        #0.5;
        rst_n = 1'b1;

        // reset state
        check("reset reg_data_out", 16'd0, 16'(reg_data_out));
        check("reset ctrl and mask", 16'd0, {ppuctrl, ppumask});
        check("reset vaddr", 16'd0, 16'(vaddr));
        check("reset fine_x", 16'd0, 16'(fine_x));
        check("reset requests", 16'd0,
              16'({vram_req.we, vram_req.re, pal_req.we, pal_req.re}));

        // control and mask writes
        for (int k = 0; k < 4; k++) begin
            c = rand_byte();
            m = rand_byte();
            bus_cycle(ppu_reg_pkg::PPUCTRL, 1'b1, c);
            check("ctrl_mask ppuctrl", 16'(c), 16'(ppuctrl));
            bus_cycle(ppu_reg_pkg::PPUMASK, 1'b1, m);
            check("ctrl_mask ppumask", 16'(m), 16'(ppumask));
            check_status("ctrl_mask status", 3'b000);
        end

        // address and scroll pairs
        read_status();
        a_hi = rand_byte();
        a_lo = rand_byte();
        bus_cycle(ppu_reg_pkg::PPUADDR, 1'b1, a_hi);
        bus_cycle(ppu_reg_pkg::PPUADDR, 1'b1, a_lo);
        check("addr_scroll vaddr", 16'({a_hi[6:0], a_lo}), 16'(vaddr));
        bus_cycle(ppu_reg_pkg::PPUADDR, 1'b1, rand_byte());
        read_status();
        a_hi = rand_byte();
        a_lo = rand_byte();
        bus_cycle(ppu_reg_pkg::PPUADDR, 1'b1, a_hi);
        bus_cycle(ppu_reg_pkg::PPUADDR, 1'b1, a_lo);
        check("addr_scroll toggle reset", 16'({a_hi[6:0], a_lo}), 16'(vaddr));
        c  = rand_byte();
        sx = rand_byte();
        sy = rand_byte();
        // fine_y, nt, coarse_y, coarse_x
        t = {sy[2:0], c[1:0], sy[7:3], sx[7:3]};
        // inverted high byte, so any bit the ctrl and scroll writes miss shows up
        read_status();
        bus_cycle(ppu_reg_pkg::PPUADDR, 1'b1, {1'b0, ~t[14:8]});
        bus_cycle(ppu_reg_pkg::PPUCTRL, 1'b1, c);
        // the toggle now sits at the second write
        bus_cycle(ppu_reg_pkg::PPUSCROLL, 1'b1, sy);
        bus_cycle(ppu_reg_pkg::PPUSCROLL, 1'b1, sx);
        check("addr_scroll fine_x", 16'(sx[2:0]), 16'(fine_x));
        bus_cycle(ppu_reg_pkg::PPUADDR, 1'b1, t[7:0]);
        check("addr_scroll temporary", 16'(t), 16'(vaddr));

        // nametable writes, both mirroring modes
        for (int mi = 0; mi < 2; mi++) begin
            mode      = mi[0] ? ppu_reg_pkg::MIRROR_HORZ : ppu_reg_pkg::MIRROR_VERT;
            mirroring = mode;
            bus_cycle(ppu_reg_pkg::PPUCTRL, 1'b1, 8'h00);
            d  = rand_byte();
            na = {2'b10, d[3:0], rand_byte()};
            set_vaddr(na);
            for (int k = 0; k < 3; k++) begin
                d = rand_byte();
                start_access(ppu_reg_pkg::PPUDATA, 1'b1, d);
                #1;
                check("nt_write we", 16'd1, 16'(vram_req.we));
                check("nt_write addr", 16'(mirror_index(na, mode)), 16'(vram_req.addr));
                finish_access();
                check("nt_write memory", 16'(d), 16'(nt_mem[mirror_index(na, mode)]));
                na = na + 14'd1;
                check("nt_write step 1", 16'(na), 16'(vaddr));
            end
            bus_cycle(ppu_reg_pkg::PPUCTRL, 1'b1, 8'h04);
            d = rand_byte();
            bus_cycle(ppu_reg_pkg::PPUDATA, 1'b1, d);
            check("nt_write memory", 16'(d), 16'(nt_mem[mirror_index(na, mode)]));
            na = na + 14'd32;
            check("nt_write step 32", 16'(na), 16'(vaddr));
        end

        // buffered nametable reads, direct palette reads, ignored pattern space
        mirroring = ppu_reg_pkg::MIRROR_VERT;
        bus_cycle(ppu_reg_pkg::PPUCTRL, 1'b1, 8'h00);
        d  = rand_byte();
        na = {2'b10, d[3:0], rand_byte()};
        set_vaddr(na);
        for (int k = 0; k < 3; k++) begin
            bus_cycle(ppu_reg_pkg::PPUDATA, 1'b0, 8'h00);
            check("data_read buffered", 16'(exp_buf), 16'(reg_data_out));
            exp_buf = nt_mem[mirror_index(na, ppu_reg_pkg::MIRROR_VERT)];
            na      = na + 14'd1;
        end
        d = rand_byte();
        set_vaddr(14'h3F00);
        bus_cycle(ppu_reg_pkg::PPUDATA, 1'b1, d);
        set_vaddr(14'h3F10);
        start_access(ppu_reg_pkg::PPUDATA, 1'b0, 8'h00);
        #1;
        check("data_read palette alias", 16'd0, 16'(pal_req.addr));
        check("data_read palette re", 16'd1, 16'(pal_req.re));
        finish_access();
        check("data_read palette 3f10", 16'(d), 16'(reg_data_out));
        d  = rand_byte();
        pa = {9'h1F8, d[4:0]};
        set_vaddr(pa);
        bus_cycle(ppu_reg_pkg::PPUDATA, 1'b0, 8'h00);
        check("data_read palette", 16'(pal_mem[pal_index(pa)]), 16'(reg_data_out));
        set_vaddr(na);
        bus_cycle(ppu_reg_pkg::PPUDATA, 1'b0, 8'h00);
        check("data_read buffer kept", 16'(exp_buf), 16'(reg_data_out));
        // the status read inside set_vaddr loads the last written low bits
        prev = {3'b000, exp_low};
        set_vaddr(14'h0123);
        bus_cycle(ppu_reg_pkg::PPUDATA, 1'b0, 8'h00);
        check("data_read pattern", 16'(prev), 16'(reg_data_out));

        // status flags
        e = '0;
        e.sp_over_set = 1'b1;
        e.sp_zero_set = 1'b1;
        e.vblank_set  = 1'b1;
        pulse_evt(e);
        check_status("status all set", 3'b111);
        check_status("status vblank read clear", 3'b011);
        e = '0;
        e.sp_over_clr = 1'b1;
        e.sp_zero_clr = 1'b1;
        pulse_evt(e);
        check_status("status cleared", 3'b000);
        pulse_evt('1);
        check_status("status clear wins from low", 3'b000);
        e = '0;
        e.sp_over_set = 1'b1;
        e.sp_zero_set = 1'b1;
        e.vblank_set  = 1'b1;
        pulse_evt(e);
        pulse_evt('1);
        check_status("status clear wins from high", 3'b000);
        e = '0;
        e.vblank_set = 1'b1;
        pulse_evt(e);
        check_status("status vblank set", 3'b100);
        check_status("status vblank gone", 3'b000);

        if (err_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- ppu_reg_top.f
design/ppu_reg_pkg.sv
design/reg_access.sv
design/loopy_addr_regs.sv
design/ppudata_port.sv
design/ppu_status_flags.sv
design/ppu_reg_top.sv
sim/tb_ppu_reg.sv

//--- Makefile
# Verilator build and run for the PPU register block testbench

VERILATOR ?= verilator
TOP       ?= tb_ppu_reg
FILELIST  ?= ppu_reg_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass line shows up in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
